// ==== hdl/rv32_pkg.sv ====
/*
  Shared types and encodings for the two-stage RV32I core.
  Only the opcodes and function codes that the core executes are listed.
*/

package rv32_pkg;

  // --------------------------------------------------------------------------
  // Basic word types
  // --------------------------------------------------------------------------

  // Data, address and instruction words
  typedef logic [31:0] word_t;

  // Register file index, x0 to x31
  typedef logic [4:0] reg_idx_t;

  // --------------------------------------------------------------------------
  // Instruction encodings
  // --------------------------------------------------------------------------

  // Major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  // funct3 values for OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 values for BRANCH
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // funct7 values for OP
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // ALU operations, PASS_B forwards operand b (used by LUI)
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  // --------------------------------------------------------------------------
  // Core constants
  // --------------------------------------------------------------------------

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0200;

  // ADDI x0, x0, 0 used as pipeline bubble
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== hdl/fetch_stage.sv ====
/*
  Fetch stage: PC register and instruction memory read.
  Memory returns byte-swapped words; a busy cycle holds the PC unless
  stage two redirects.
*/

module fetch_stage (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           imem_busy,
  input  rv32_pkg::word_t imem_rdata,
  input  logic           redirect,
  input  rv32_pkg::word_t redirect_pc,
  output rv32_pkg::word_t imem_addr,
  output rv32_pkg::word_t fetch_pc,
  output rv32_pkg::word_t fetch_instr
);
  import rv32_pkg::*;

  word_t pc;
  word_t pc4;
  word_t npc;

  // Sequential successor
  assign pc4 = pc + 32'd4;

  // Redirect wins over the sequential path
  assign npc = redirect ? redirect_pc : pc4;

  // PC register
  // Advances on a finished read, or at once on a redirect
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (redirect || !imem_busy) begin
      pc <= npc;
    end
  end

  // Core only reads, so the address is simply the PC
  assign imem_addr = pc;

  // Memory holds words in the opposite byte order
  assign fetch_instr = {imem_rdata[7:0], imem_rdata[15:8],
                        imem_rdata[23:16], imem_rdata[31:24]};

  // Address of the word now on fetch_instr
  assign fetch_pc = pc;

endmodule

// ==== hdl/pipeline_control.sv ====
/*
  Fetch-to-execute boundary register.
  A busy memory or a redirect loads a NOP bubble with ex_valid low,
  so only one slot behind a taken branch is ever lost.
*/

module pipeline_control (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            imem_busy,
  input  logic            redirect,
  input  rv32_pkg::word_t fetch_pc,
  input  rv32_pkg::word_t fetch_instr,
  output logic            ex_valid,
  output rv32_pkg::word_t ex_pc,
  output rv32_pkg::word_t ex_instr
);
  import rv32_pkg::*;

  logic accept;

  // Take the fetched word only when it is real and on the right path
  assign accept = !imem_busy && !redirect;

  // --------------------------------------------------------------------------
  // Stage register
  // --------------------------------------------------------------------------

  // Reset to a bubble so stage two sees a known NOP
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid <= 1'b0;
      ex_pc    <= RESET_PC;
      ex_instr <= NOP_INSTR;
    end else begin
      // Slot address follows the fetch stage either way
      ex_pc <= fetch_pc;
      if (accept) begin
        ex_valid <= 1'b1;
        ex_instr <= fetch_instr;
      end else begin
        // Stall or flush
        ex_valid <= 1'b0;
        ex_instr <= NOP_INSTR;
      end
    end
  end

endmodule

// ==== hdl/decode_unit.sv ====
/*
  Stage-two decoder. Purely combinational.
  Unsupported encodings and bubbles write nothing and never redirect.
*/

module decode_unit (
  input  logic               ex_valid,
  input  rv32_pkg::word_t    ex_instr,
  output rv32_pkg::reg_idx_t rs1_idx,
  output rv32_pkg::reg_idx_t rs2_idx,
  output rv32_pkg::reg_idx_t rd_idx,
  output rv32_pkg::word_t    imm,
  output rv32_pkg::alu_op_t  alu_op,
  output logic               use_imm,
  output logic               is_branch,
  output logic               branch_ne,
  output logic               is_jal,
  output logic               writes_rd
);
  import rv32_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;

  // Fixed field positions
  assign opcode  = opcode_t'(ex_instr[6:0]);
  assign funct3  = ex_instr[14:12];
  assign funct7  = ex_instr[31:25];
  assign rd_idx  = ex_instr[11:7];
  assign rs1_idx = ex_instr[19:15];
  assign rs2_idx = ex_instr[24:20];

  // --------------------------------------------------------------------------
  // Immediate formats
  // --------------------------------------------------------------------------
  assign imm_i = {{20{ex_instr[31]}}, ex_instr[31:20]};
  assign imm_u = {ex_instr[31:12], 12'b0};
  // B and J immediates are scattered, bit 0 always zero
  assign imm_b = {{19{ex_instr[31]}}, ex_instr[31], ex_instr[7],
                  ex_instr[30:25], ex_instr[11:8], 1'b0};
  assign imm_j = {{11{ex_instr[31]}}, ex_instr[31], ex_instr[19:12],
                  ex_instr[20], ex_instr[30:21], 1'b0};

  // --------------------------------------------------------------------------
  // Control decode
  // --------------------------------------------------------------------------
  always_comb begin
    // Defaults describe an instruction with no effect
    imm       = '0;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jal    = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      OP: begin
        writes_rd = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
          {F7_SUB, F3_ADD_SUB}:  alu_op = ALU_SUB;
          {F7_BASE, F3_SLT}:     alu_op = ALU_SLT;
          {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
          {F7_BASE, F3_OR}:      alu_op = ALU_OR;
          {F7_BASE, F3_AND}:     alu_op = ALU_AND;
          default:               writes_rd = 1'b0;
        endcase
      end
      OP_IMM: begin
        // Only ADDI is supported
        imm       = imm_i;
        use_imm   = 1'b1;
        writes_rd = (funct3 == F3_ADD_SUB);
      end
      LUI: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        alu_op    = ALU_PASS_B;
        writes_rd = 1'b1;
      end
      BRANCH: begin
        imm       = imm_b;
        is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        branch_ne = (funct3 == F3_BNE);
      end
      JAL: begin
        imm       = imm_j;
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      default: ;
    endcase
    // A bubble must have no side effects
    if (!ex_valid) begin
      is_branch = 1'b0;
      is_jal    = 1'b0;
      writes_rd = 1'b0;
    end
  end

endmodule

// ==== hdl/execute_unit.sv ====
/*
  Stage-two ALU, branch compare and target adder. Combinational.
  Expects is_branch and is_jal already qualified by ex_valid.
*/

module execute_unit (
  input  rv32_pkg::word_t   ex_pc,
  input  rv32_pkg::word_t   rs1_data,
  input  rv32_pkg::word_t   rs2_data,
  input  rv32_pkg::word_t   imm,
  input  rv32_pkg::alu_op_t alu_op,
  input  logic              use_imm,
  input  logic              is_branch,
  input  logic              branch_ne,
  input  logic              is_jal,
  output rv32_pkg::word_t   wb_data,
  output logic              redirect,
  output rv32_pkg::word_t   redirect_pc
);
  import rv32_pkg::*;

  word_t opnd_b;
  word_t alu_out;
  logic  equal;
  logic  taken;

  // Second operand is the immediate for ADDI and LUI
  assign opnd_b = use_imm ? imm : rs2_data;

  // --------------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------------
  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_out = rs1_data + opnd_b;
      ALU_SUB:    alu_out = rs1_data - opnd_b;
      ALU_AND:    alu_out = rs1_data & opnd_b;
      ALU_OR:     alu_out = rs1_data | opnd_b;
      ALU_XOR:    alu_out = rs1_data ^ opnd_b;
      // Signed compare, result is 0 or 1
      ALU_SLT:    alu_out = {31'b0, $signed(rs1_data) < $signed(opnd_b)};
      ALU_PASS_B: alu_out = opnd_b;
      default:    alu_out = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Control flow
  // --------------------------------------------------------------------------

  // BEQ and BNE share one equality compare
  assign equal = (rs1_data == rs2_data);
  assign taken = is_branch && (branch_ne ? !equal : equal);

  // Both branch and JAL targets are pc-relative
  assign redirect    = taken || is_jal;
  assign redirect_pc = ex_pc + imm;

  // JAL links the return address
  assign wb_data = is_jal ? (ex_pc + 32'd4) : alu_out;

endmodule

// ==== hdl/result_unit.sv ====
/*
  Register file and retire report. Reads are combinational, writes land
  at the edge that ends stage two. x0 always reads zero.
*/

module result_unit (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               ex_valid,
  input  rv32_pkg::word_t    ex_pc,
  input  rv32_pkg::reg_idx_t rs1_idx,
  input  rv32_pkg::reg_idx_t rs2_idx,
  input  rv32_pkg::reg_idx_t rd_idx,
  input  logic               writes_rd,
  input  rv32_pkg::word_t    wb_data,
  output rv32_pkg::word_t    rs1_data,
  output rv32_pkg::word_t    rs2_data,
  output logic               retire_valid,
  output rv32_pkg::word_t    retire_pc,
  output rv32_pkg::reg_idx_t retire_rd,
  output rv32_pkg::word_t    retire_data
);
  import rv32_pkg::*;

  word_t regs [32];
  logic  wr_en;

  // Writes to x0 are dropped here and reported as no write
  assign wr_en = writes_rd && (rd_idx != '0);

  // Register file, cleared by reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_idx] <= wb_data;
    end
  end

  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  // --------------------------------------------------------------------------
  // Retire report
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ex_valid;
    end
  end

  // Payload, only meaningful with retire_valid
  always_ff @(posedge CLK) begin
    retire_pc   <= ex_pc;
    retire_rd   <= wr_en ? rd_idx : '0;
    retire_data <= wr_en ? wb_data : '0;
  end

endmodule

// ==== hdl/core_top.sv ====
/*
  Two-stage RV32I core: fetch, then decode/execute/writeback.
  No loads, stores, CSRs or traps. Results are seen on the retire port.
*/

module core_top (
  input  logic               CLK,
  input  logic               nRST,
  // Instruction memory
  output rv32_pkg::word_t    imem_addr,
  input  logic               imem_busy,
  input  rv32_pkg::word_t    imem_rdata,
  // Retire port
  output logic               retire_valid,
  output rv32_pkg::word_t    retire_pc,
  output rv32_pkg::reg_idx_t retire_rd,
  output rv32_pkg::word_t    retire_data
);
  import rv32_pkg::*;

  // Fetch to stage boundary
  word_t    fetch_pc;
  word_t    fetch_instr;

  // Stage boundary to stage two
  logic     ex_valid;
  word_t    ex_pc;
  word_t    ex_instr;

  // Decoded controls
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  word_t    imm;
  alu_op_t  alu_op;
  logic     use_imm;
  logic     is_branch;
  logic     branch_ne;
  logic     is_jal;
  logic     writes_rd;

  // Operands, result and redirect
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    wb_data;
  logic     redirect;
  word_t    redirect_pc;

  // --------------------------------------------------------------------------
  // Stage one
  // --------------------------------------------------------------------------
  fetch_stage u_fetch_stage (
    .CLK         (CLK),
    .nRST        (nRST),
    .imem_busy   (imem_busy),
    .imem_rdata  (imem_rdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_addr   (imem_addr),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr)
  );

  pipeline_control u_pipeline_control (
    .CLK         (CLK),
    .nRST        (nRST),
    .imem_busy   (imem_busy),
    .redirect    (redirect),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .ex_valid    (ex_valid),
    .ex_pc       (ex_pc),
    .ex_instr    (ex_instr)
  );

  // --------------------------------------------------------------------------
  // Stage two
  // --------------------------------------------------------------------------
  decode_unit u_decode_unit (
    .ex_valid  (ex_valid),
    .ex_instr  (ex_instr),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rd_idx    (rd_idx),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .is_branch (is_branch),
    .branch_ne (branch_ne),
    .is_jal    (is_jal),
    .writes_rd (writes_rd)
  );

  execute_unit u_execute_unit (
    .ex_pc       (ex_pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .is_branch   (is_branch),
    .branch_ne   (branch_ne),
    .is_jal      (is_jal),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  result_unit u_result_unit (
    .CLK          (CLK),
    .nRST         (nRST),
    .ex_valid     (ex_valid),
    .ex_pc        (ex_pc),
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .rd_idx       (rd_idx),
    .writes_rd    (writes_rd),
    .wb_data      (wb_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

// ==== tb/core_tb_assert.sv ====
/*
  Concurrent checks on the fetch-to-execute register, bound into
  pipeline_control. Checks are disabled while nRST is low.
*/

module core_tb_assert (
  input logic            CLK,
  input logic            nRST,
  input logic            imem_busy,
  input logic            redirect,
  input logic            ex_valid,
  input rv32_pkg::word_t ex_pc,
  input rv32_pkg::word_t ex_instr
);

  // --------------------------------------------------------------------------
  // Bubble rules
  // --------------------------------------------------------------------------

  // Slot behind a taken branch or JAL is flushed
  flush_after_redirect: assert property (
    @(posedge CLK) disable iff (!nRST) redirect |=> !ex_valid
  ) else $error("ex_valid high in the cycle after a redirect");

  // Busy memory word never enters stage two
  bubble_after_busy: assert property (
    @(posedge CLK) disable iff (!nRST) imem_busy |=> !ex_valid
  ) else $error("ex_valid high in the cycle after imem_busy");

  // Stage register always holds known values
  known_outputs: assert property (
    @(posedge CLK) disable iff (!nRST) !$isunknown({ex_valid, ex_pc, ex_instr})
  ) else $error("Unknown value on a pipeline_control output");

endmodule

bind pipeline_control core_tb_assert u_core_tb_assert (
  .CLK       (CLK),
  .nRST      (nRST),
  .imem_busy (imem_busy),
  .redirect  (redirect),
  .ex_valid  (ex_valid),
  .ex_pc     (ex_pc),
  .ex_instr  (ex_instr)
);

// ==== tb/core_tb.sv ====
/*
  Testbench for core_top. Program rows sit at RESET_PC + 4 * row; a taken
  branch or JAL may only jump over one flushed row. The program runs twice,
  first without and then with random imem_busy cycles.
*/

module core_tb;
  import rv32_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 3;
  localparam int RETIRE_TIMEOUT = 40;
  localparam int MEM_WORDS      = 256;
  localparam int MAX_ROWS       = 32;

  logic     CLK;
  logic     nRST;
  word_t    imem_addr;
  logic     imem_busy;
  word_t    imem_rdata;
  logic     retire_valid;
  word_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_data;

  // Memory image, each word stored byte-swapped
  word_t    imem_mem [MEM_WORDS];

  // Program table, one row per instruction slot
  word_t    row_instr [MAX_ROWS];
  reg_idx_t row_rd    [MAX_ROWS];
  word_t    row_data  [MAX_ROWS];
  logic     row_skip  [MAX_ROWS];
  int       num_rows;

  core_top u_core_top (
    .CLK          (CLK),
    .nRST         (nRST),
    .imem_addr    (imem_addr),
    .imem_busy    (imem_busy),
    .imem_rdata   (imem_rdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  // Combinational read, 1 KB wraps
  assign imem_rdata = imem_mem[imem_addr[9:2]];

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // --------------------------------------------------------------------------
  // Instruction encodings, straight from the ISA formats
  // --------------------------------------------------------------------------
  function automatic word_t addi_word(reg_idx_t rd, reg_idx_t rs1, word_t imm);
    return {imm[11:0], rs1, F3_ADD_SUB, rd, OP_IMM};
  endfunction

  function automatic word_t rr_word(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic word_t lui_word(reg_idx_t rd, logic [19:0] upper);
    return {upper, rd, LUI};
  endfunction

  function automatic word_t branch_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                        word_t off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
  endfunction

  function automatic word_t jal_word(reg_idx_t rd, word_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  // Memory keeps the opposite byte order
  function automatic word_t byte_swap(word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // --------------------------------------------------------------------------
  // Program table
  // --------------------------------------------------------------------------
  task automatic add_row(input word_t instr, input reg_idx_t rd, input word_t data);
    row_instr[num_rows] = instr;
    row_rd[num_rows]    = rd;
    row_data[num_rows]  = data;
    row_skip[num_rows]  = 1'b0;
    num_rows++;
  endtask

  // Slot that must be flushed and never retire
  task automatic add_flushed(input word_t instr);
    row_instr[num_rows] = instr;
    row_rd[num_rows]    = '0;
    row_data[num_rows]  = '0;
    row_skip[num_rows]  = 1'b1;
    num_rows++;
  endtask

  // Expected data follows from the rows above, x1 = 5 and x2 = -3
  task automatic build_program();
    num_rows = 0;
    add_row(addi_word(5'd1, 5'd0, 5), 5'd1, 32'd5);
    add_row(addi_word(5'd2, 5'd0, -3), 5'd2, 32'hffff_fffd);
    add_row(lui_word(5'd3, 20'h12345), 5'd3, 32'h1234_5000);
    add_row(rr_word(F7_BASE, F3_ADD_SUB, 5'd4, 5'd1, 5'd2), 5'd4, 32'd2);
    add_row(rr_word(F7_SUB, F3_ADD_SUB, 5'd5, 5'd1, 5'd2), 5'd5, 32'd8);
    add_row(rr_word(F7_BASE, F3_AND, 5'd6, 5'd1, 5'd2), 5'd6, 32'd5);
    add_row(rr_word(F7_BASE, F3_OR, 5'd7, 5'd1, 5'd2), 5'd7, 32'hffff_fffd);
    add_row(rr_word(F7_BASE, F3_XOR, 5'd8, 5'd1, 5'd2), 5'd8, 32'hffff_fff8);
    // Signed compare, -3 < 5
    add_row(rr_word(F7_BASE, F3_SLT, 5'd9, 5'd2, 5'd1), 5'd9, 32'd1);
    add_row(rr_word(F7_BASE, F3_SLT, 5'd10, 5'd1, 5'd2), 5'd10, 32'd0);
    // x0 write is dropped, then x0 reads back as zero
    add_row(addi_word(5'd0, 5'd1, 7), 5'd0, 32'd0);
    add_row(rr_word(F7_BASE, F3_ADD_SUB, 5'd11, 5'd0, 5'd1), 5'd11, 32'd5);
    // Taken BEQ and BNE, each jumps over one flushed slot
    add_row(branch_word(F3_BEQ, 5'd1, 5'd1, 8), 5'd0, 32'd0);
    add_flushed(addi_word(5'd12, 5'd0, 99));
    add_row(branch_word(F3_BNE, 5'd1, 5'd2, 8), 5'd0, 32'd0);
    add_flushed(addi_word(5'd12, 5'd0, 77));
    // Not taken, fall through
    add_row(branch_word(F3_BEQ, 5'd1, 5'd2, 8), 5'd0, 32'd0);
    add_row(branch_word(F3_BNE, 5'd1, 5'd11, 8), 5'd0, 32'd0);
    // JAL at 0x248 links 0x24c
    add_row(jal_word(5'd13, 8), 5'd13, 32'h0000_024c);
    add_flushed(addi_word(5'd12, 5'd0, 55));
    add_row(rr_word(F7_BASE, F3_ADD_SUB, 5'd14, 5'd13, 5'd4), 5'd14, 32'h0000_024e);
    // x12 stays zero if every flush worked
    add_row(addi_word(5'd15, 5'd12, 1), 5'd15, 32'd1);
    add_row(lui_word(5'd16, 20'hfffff), 5'd16, 32'hffff_f000);
    // Sum wraps past 32 bits
    add_row(rr_word(F7_BASE, F3_ADD_SUB, 5'd17, 5'd16, 5'd3), 5'd17, 32'h1234_4000);
  endtask

  // Fill with ADDI x0 carrying the byte address, then place the program
  task automatic load_memory();
    int base;
    base = RESET_PC >> 2;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem_mem[i] = byte_swap(addi_word(5'd0, 5'd0, i * 4));
    end
    for (int r = 0; r < num_rows; r++) begin
      imem_mem[base + r] = byte_swap(row_instr[r]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at time %0t: %s is x%0d, expected x%0d",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                                  $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // Sequencing
  // --------------------------------------------------------------------------

  // Inputs change 1 unit after the edge, outputs are sampled there too
  task automatic step_cycle(input logic random_busy);
    @(posedge CLK);
    #1;
    if (random_busy) begin
      imem_busy = (($urandom % 3) == 0);
    end else begin
      imem_busy = 1'b0;
    end
  endtask

  task automatic apply_reset();
    nRST      = 1'b0;
    imem_busy = 1'b0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge CLK);
      #1;
      check_flag(retire_valid, 1'b0, "retire_valid during reset");
    end
    nRST = 1'b1;
    check_word(imem_addr, RESET_PC, "first imem_addr after reset");
  endtask

  task automatic wait_retire(input int row, input logic random_busy);
    int cycles;
    cycles = 0;
    step_cycle(random_busy);
    while (!retire_valid) begin
      cycles++;
      if (cycles > RETIRE_TIMEOUT) begin
        stop_with_failure($sformatf("Timeout: row %0d did not retire within %0d cycles",
                                    row, RETIRE_TIMEOUT));
      end
      step_cycle(random_busy);
    end
  endtask

  // Every retirement must match the next row that is not flushed
  task automatic run_program(input int run, input logic random_busy);
    word_t exp_pc;
    for (int r = 0; r < num_rows; r++) begin
      if (!row_skip[r]) begin
        wait_retire(r, random_busy);
        exp_pc = RESET_PC + r * 4;
        check_word(retire_pc, exp_pc, $sformatf("run %0d row %0d retire_pc", run, r));
        check_idx(retire_rd, row_rd[r], $sformatf("run %0d row %0d retire_rd", run, r));
        check_word(retire_data, row_data[r],
                   $sformatf("run %0d row %0d retire_data", run, r));
      end
    end
  endtask

  initial begin
    void'($urandom(32'h346));
    nRST      = 1'b0;
    imem_busy = 1'b0;
    build_program();
    load_memory();

    // Run 0 never stalls, run 1 stalls at random
    apply_reset();
    run_program(0, 1'b0);
    apply_reset();
    run_program(1, 1'b1);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/rv32_pkg.sv
hdl/fetch_stage.sv
hdl/pipeline_control.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/result_unit.sv
hdl/core_top.sv
tb/core_tb_assert.sv
tb/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator.
# A failed build or run, or the fail message in the log, gives exit status 1.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=core_sim
LOG=sim.log

verilator --binary --timing --assert \
  --top-module core_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status, see $LOG"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
